/* source/ami_pkg.sv */
`default_nettype none

package ami_pkg;

  // ************************************************************
  // Memory geometry
  // ************************************************************

  localparam int DATA_W      = 32;
  localparam int ADDR_W      = 10;
  localparam int MEM_WORDS   = 1024;

  // Request queue depth kept to a power of two
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = 2;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // ************************************************************
  // Bus payloads
  // ************************************************************

  // One aligned word per request
  typedef struct packed {
    logic  valid;
    logic  is_write;
    addr_t addr;
    word_t data;
  } mem_req_t;

  // Read data as a single-cycle pulse
  typedef struct packed {
    logic  valid;
    word_t data;
  } mem_resp_t;

endpackage

`default_nettype wire

/* source/drive_pkg.sv */
`default_nettype none

package drive_pkg;

  // ************************************************************
  // Run description
  // ************************************************************

  // Word count goes up to a full memory, so one bit wider than an address
  typedef logic [10:0] count_t;
  typedef logic [31:0] cycle_t;
  typedef logic [7:0]  scale_t;

  typedef struct packed {
    ami_pkg::addr_t src_base;
    ami_pkg::addr_t dst_base;
    count_t         count;
    scale_t         scale;
  } run_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    RUNNING,
    DRAINING
  } run_state_t;

  // Engine limit on reads in flight plus writes waiting
  localparam int MAX_INFLIGHT = 2;
  typedef logic [1:0] inflight_t;

endpackage

`default_nettype wire

/* source/run_control.sv */
`timescale 1ns/1ps
`default_nettype none

module run_control (
  input  logic                clk,
  input  logic                rst,
  input  logic                run_start,
  input  drive_pkg::run_cfg_t run_cfg,
  input  logic                queue_empty,
  input  logic                eng_done,
  output logic                eng_start,
  output drive_pkg::run_cfg_t cfg,
  output logic                busy,
  output logic                run_done,
  output drive_pkg::cycle_t   run_cycles
);

  drive_pkg::run_state_t state;

  assign busy = (state != drive_pkg::IDLE);

  // ************************************************************
  // Run sequencing
  // ************************************************************

  // run_cycles counts every busy cycle plus the run_done cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= drive_pkg::IDLE;
      eng_start  <= 1'b0;
      run_done   <= 1'b0;
      run_cycles <= '0;
    end else begin
      eng_start <= 1'b0;
      run_done  <= 1'b0;
      case (state)
        drive_pkg::IDLE: begin
          if (run_start) begin
            state      <= drive_pkg::RUNNING;
            eng_start  <= 1'b1;
            run_cycles <= drive_pkg::cycle_t'(1);
          end
        end
        drive_pkg::RUNNING: begin
          run_cycles <= run_cycles + 1'b1;
          if (eng_done) begin
            state <= drive_pkg::DRAINING;
          end
        end
        drive_pkg::DRAINING: begin
          run_cycles <= run_cycles + 1'b1;
          // Empty queue means the last write already hit memory
          if (queue_empty) begin
            state    <= drive_pkg::IDLE;
            run_done <= 1'b1;
          end
        end
        default: begin
          state <= drive_pkg::IDLE;
        end
      endcase
    end
  end

  // Config held for the whole run
  always_ff @(posedge clk) begin
    if ((state == drive_pkg::IDLE) && run_start) begin
      cfg <= run_cfg;
    end
  end

  a_no_done_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    (state == drive_pkg::IDLE) |-> !eng_done
  );

endmodule

`default_nettype wire

/* source/layer_stream_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_stream_engine (
  input  logic                clk,
  input  logic                rst,
  input  logic                eng_start,
  input  drive_pkg::run_cfg_t cfg,
  input  logic                queue_full,
  input  ami_pkg::mem_resp_t  rd_resp,
  output ami_pkg::mem_req_t   push_req,
  output logic                eng_done
);

  logic                 active;
  drive_pkg::count_t    rd_idx;
  drive_pkg::count_t    wr_idx;
  drive_pkg::inflight_t inflight;

  // Two-entry store for scaled words waiting on the push slot
  ami_pkg::word_t       pend_data [2];
  logic                 pend_wp;
  logic                 pend_rp;
  logic [1:0]           pend_cnt;

  logic                 push_wr;
  logic                 push_rd;
  ami_pkg::word_t       scaled;
  ami_pkg::addr_t       rd_addr;
  ami_pkg::addr_t       wr_addr;

  // Low 32 bits of the product
  assign scaled  = rd_resp.data * ami_pkg::word_t'(cfg.scale);

  // Addresses wrap at the memory size
  assign rd_addr = cfg.src_base + ami_pkg::addr_t'(rd_idx);
  assign wr_addr = cfg.dst_base + ami_pkg::addr_t'(wr_idx);

  // ************************************************************
  // Push slot arbitration
  // ************************************************************

  // Pending write wins over a new read
  assign push_wr = active && !queue_full && (pend_cnt != 2'd0);
  assign push_rd = active && !queue_full && (pend_cnt == 2'd0) &&
                   (rd_idx < cfg.count) && (inflight < drive_pkg::MAX_INFLIGHT);

  always_comb begin
    push_req          = '0;
    push_req.valid    = push_wr || push_rd;
    push_req.is_write = push_wr;
    push_req.addr     = push_wr ? wr_addr : rd_addr;
    push_req.data     = push_wr ? pend_data[pend_rp] : '0;
  end

  // ************************************************************
  // Progress tracking
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      eng_done <= 1'b0;
      rd_idx   <= '0;
      wr_idx   <= '0;
      inflight <= '0;
      pend_wp  <= 1'b0;
      pend_rp  <= 1'b0;
      pend_cnt <= '0;
    end else begin
      eng_done <= 1'b0;
      if (eng_start) begin
        rd_idx   <= '0;
        wr_idx   <= '0;
        // Empty run finishes straight away
        active   <= (cfg.count != '0);
        eng_done <= (cfg.count == '0);
      end else begin
        if (push_rd) begin
          rd_idx <= rd_idx + 1'b1;
        end
        if (push_wr) begin
          wr_idx  <= wr_idx + 1'b1;
          pend_rp <= ~pend_rp;
          if ((wr_idx + 1'b1) == cfg.count) begin
            active   <= 1'b0;
            eng_done <= 1'b1;
          end
        end
      end

      // A response moves an item from read to pending and leaves inflight alone
      case ({push_rd, push_wr})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase

      if (rd_resp.valid) begin
        pend_wp <= ~pend_wp;
      end
      case ({rd_resp.valid, push_wr})
        2'b10:   pend_cnt <= pend_cnt + 1'b1;
        2'b01:   pend_cnt <= pend_cnt - 1'b1;
        default: pend_cnt <= pend_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_resp.valid) begin
      pend_data[pend_wp] <= scaled;
    end
  end

  // Outstanding reads are inflight items not yet sitting in the store
  a_resp_has_read: assert property (
    @(posedge clk) disable iff (rst)
    rd_resp.valid |-> (inflight > drive_pkg::inflight_t'(pend_cnt))
  );

endmodule

`default_nettype wire

/* source/req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module req_fifo (
  input  logic              clk,
  input  logic              rst,
  input  ami_pkg::mem_req_t push_req,
  input  logic              pop,
  output logic              full,
  output logic              empty,
  output ami_pkg::mem_req_t head
);

  ami_pkg::mem_req_t           entries [ami_pkg::QUEUE_DEPTH];
  logic [ami_pkg::QPTR_W-1:0]  wr_ptr;
  logic [ami_pkg::QPTR_W-1:0]  rd_ptr;
  logic [ami_pkg::QPTR_W:0]    level;
  logic                        do_push;
  logic                        do_pop;

  assign do_push = push_req.valid;
  assign do_pop  = pop && !empty;

  assign full    = (level == ami_pkg::QUEUE_DEPTH);
  assign empty   = (level == '0);

  // Head valid follows occupancy, not the stored strobe
  always_comb begin
    head       = entries[rd_ptr];
    head.valid = !empty;
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      entries[wr_ptr] <= push_req;
    end
  end

  // Pointers wrap naturally at the depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    (push_req.valid && full) |-> pop
  );

endmodule

`default_nettype wire

/* source/mem_responder.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_responder (
  input  logic               clk,
  input  logic               rst,
  input  ami_pkg::mem_req_t  head,
  output logic               pop,
  output ami_pkg::mem_resp_t rd_resp,
  input  logic               host_wr,
  input  logic               host_rd,
  input  ami_pkg::addr_t     host_addr,
  input  ami_pkg::word_t     host_wdata,
  output ami_pkg::word_t     host_rdata,
  output logic               host_rd_valid
);

  ami_pkg::word_t mem [ami_pkg::MEM_WORDS];
  ami_pkg::word_t rd_q;
  logic           resp_valid;
  ami_pkg::addr_t mem_addr;
  ami_pkg::word_t mem_wdata;
  logic           mem_we;
  logic           mem_re;

  // Queue head is always served in the cycle it shows up
  assign pop = head.valid;

  // ************************************************************
  // Single memory port shared by queue and host
  // ************************************************************

  assign mem_addr  = head.valid ? head.addr : host_addr;
  assign mem_wdata = head.valid ? head.data : host_wdata;
  assign mem_we    = head.valid ? head.is_write : host_wr;
  assign mem_re    = head.valid ? !head.is_write : host_rd;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    if (mem_re) begin
      rd_q <= mem[mem_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid    <= 1'b0;
      host_rd_valid <= 1'b0;
    end else begin
      resp_valid    <= head.valid && !head.is_write;
      host_rd_valid <= !head.valid && host_rd;
    end
  end

  // Both read paths see the same data register
  always_comb begin
    rd_resp.valid = resp_valid;
    rd_resp.data  = rd_q;
  end

  assign host_rdata = rd_q;

  // Host may only touch memory between runs
  a_host_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    (host_wr || host_rd) |-> !head.valid
  );

endmodule

`default_nettype wire

/* source/accel_drive_top.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_drive_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                run_start,
  input  drive_pkg::run_cfg_t run_cfg,
  input  logic                host_wr,
  input  logic                host_rd,
  input  ami_pkg::addr_t      host_addr,
  input  ami_pkg::word_t      host_wdata,
  output logic                busy,
  output logic                run_done,
  output drive_pkg::cycle_t   run_cycles,
  output ami_pkg::word_t      host_rdata,
  output logic                host_rd_valid
);

  logic                eng_start;
  logic                eng_done;
  drive_pkg::run_cfg_t cfg;
  logic                queue_full;
  logic                queue_empty;
  logic                pop;
  ami_pkg::mem_req_t   push_req;
  ami_pkg::mem_req_t   head;
  ami_pkg::mem_resp_t  rd_resp;

  run_control u_run_control (
    .clk         (clk),
    .rst         (rst),
    .run_start   (run_start),
    .run_cfg     (run_cfg),
    .queue_empty (queue_empty),
    .eng_done    (eng_done),
    .eng_start   (eng_start),
    .cfg         (cfg),
    .busy        (busy),
    .run_done    (run_done),
    .run_cycles  (run_cycles)
  );

  // Producer side
  layer_stream_engine u_engine (
    .clk        (clk),
    .rst        (rst),
    .eng_start  (eng_start),
    .cfg        (cfg),
    .queue_full (queue_full),
    .rd_resp    (rd_resp),
    .push_req   (push_req),
    .eng_done   (eng_done)
  );

  req_fifo u_req_fifo (
    .clk      (clk),
    .rst      (rst),
    .push_req (push_req),
    .pop      (pop),
    .full     (queue_full),
    .empty    (queue_empty),
    .head     (head)
  );

  // Consumer side
  mem_responder u_mem_responder (
    .clk           (clk),
    .rst           (rst),
    .head          (head),
    .pop           (pop),
    .rd_resp       (rd_resp),
    .host_wr       (host_wr),
    .host_rd       (host_rd),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_rdata    (host_rdata),
    .host_rd_valid (host_rd_valid)
  );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 40 ns period
  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

/* verification/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic              clk,
  input  logic              rst,
  input  logic              busy,
  input  logic              run_done,
  input  drive_pkg::cycle_t run_cycles,
  input  logic              host_rd,
  input  logic              host_rd_valid,
  input  ami_pkg::word_t    host_rdata,
  input  ami_pkg::word_t    exp_rdata,
  input  drive_pkg::cycle_t min_cycles,
  input  drive_pkg::cycle_t max_cycles,
  output int                check_count,
  output int                error_count
);

  logic busy_q;
  logic rd_q;

  // ************************************************************
  // Sampled once per rising edge
  // ************************************************************

  always @(posedge clk) begin : compare
    int   errs;
    int   checks;
    logic fell;
    errs   = 0;
    checks = 0;
    fell   = busy_q && !busy;
    if (rst) begin
      busy_q      <= 1'b0;
      rd_q        <= 1'b0;
      check_count <= 0;
      error_count <= 0;
    end else begin
      // Read data one cycle after the strobe
      if (host_rd_valid != rd_q) begin
        $display("** Error at %0t: host_rd_valid = %b, expected %b",
                 $time, host_rd_valid, rd_q);
        errs++;
      end
      if (host_rd_valid) begin
        checks++;
        if (host_rdata !== exp_rdata) begin
          $display("** Error at %0t: host_rdata = 0x%08h, expected 0x%08h",
                   $time, host_rdata, exp_rdata);
          errs++;
        end
      end
      // busy drops exactly with run_done
      if (fell != run_done) begin
        $display("** Error at %0t: run_done = %b, expected %b", $time, run_done, fell);
        errs++;
      end
      if (run_done) begin
        checks++;
        if ((run_cycles < min_cycles) || (run_cycles > max_cycles)) begin
          $display("** Error at %0t: run_cycles = %0d, expected %0d to %0d",
                   $time, run_cycles, min_cycles, max_cycles);
          errs++;
        end
      end
      busy_q      <= busy;
      rd_q        <= host_rd;
      check_count <= check_count + checks;
      error_count <= error_count + errs;
    end
  end

endmodule

`default_nettype wire

/* verification/tb_accel_drive.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_accel_drive;

  localparam int RUN_TIMEOUT  = 2000;
  localparam int READ_TIMEOUT = 8;

  logic                clk;
  logic                rst;
  logic                run_start;
  drive_pkg::run_cfg_t run_cfg;
  logic                host_wr;
  logic                host_rd;
  ami_pkg::addr_t      host_addr;
  ami_pkg::word_t      host_wdata;
  logic                busy;
  logic                run_done;
  drive_pkg::cycle_t   run_cycles;
  ami_pkg::word_t      host_rdata;
  logic                host_rd_valid;
  ami_pkg::word_t      exp_rdata;
  drive_pkg::cycle_t   min_cycles;
  drive_pkg::cycle_t   max_cycles;
  int                  check_count;
  int                  error_count;

  ami_pkg::word_t      model [ami_pkg::MEM_WORDS];
  logic [31:0]         rand_state;
  int                  tests_run;
  int                  tests_failed;
  int                  errors_at_start;
  bit                  timed_out;

  tb_clock u_clock (.clk(clk));

  accel_drive_top dut (
    .clk           (clk),
    .rst           (rst),
    .run_start     (run_start),
    .run_cfg       (run_cfg),
    .host_wr       (host_wr),
    .host_rd       (host_rd),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .busy          (busy),
    .run_done      (run_done),
    .run_cycles    (run_cycles),
    .host_rdata    (host_rdata),
    .host_rd_valid (host_rd_valid)
  );

  tb_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .busy          (busy),
    .run_done      (run_done),
    .run_cycles    (run_cycles),
    .host_rd       (host_rd),
    .host_rd_valid (host_rd_valid),
    .host_rdata    (host_rdata),
    .exp_rdata     (exp_rdata),
    .min_cycles    (min_cycles),
    .max_cycles    (max_cycles),
    .check_count   (check_count),
    .error_count   (error_count)
  );

  // ************************************************************
  // Random source
  // ************************************************************

  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, rand_state[31:8]};
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r % n);
  endfunction

  function automatic ami_pkg::word_t random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_random();
    lo = next_random();
    return {hi[15:0], lo[15:0]};
  endfunction

  // Bases either equal or far enough apart that the ranges never meet
  function automatic drive_pkg::run_cfg_t random_cfg(input int min_count, input int max_count,
                                                     input bit same_base);
    drive_pkg::run_cfg_t c;
    int                  cnt;
    int                  gap;
    cnt        = min_count + rand_below(max_count - min_count + 1);
    c.src_base = ami_pkg::addr_t'(rand_below(ami_pkg::MEM_WORDS));
    gap        = cnt + rand_below(ami_pkg::MEM_WORDS - 2 * cnt);
    c.dst_base = same_base ? c.src_base : c.src_base + ami_pkg::addr_t'(gap);
    c.count    = drive_pkg::count_t'(cnt);
    c.scale    = drive_pkg::scale_t'(rand_below(256));
    return c;
  endfunction

  // Every read comes before its own write, so a sequential loop is exact
  task automatic apply_model(input drive_pkg::run_cfg_t c);
    ami_pkg::addr_t s;
    ami_pkg::addr_t d;
    for (int i = 0; i < int'(c.count); i++) begin
      s        = c.src_base + ami_pkg::addr_t'(i);
      d        = c.dst_base + ami_pkg::addr_t'(i);
      model[d] = model[s] * ami_pkg::word_t'(c.scale);
    end
  endtask

  // ************************************************************
  // Host and run access
  // ************************************************************

  task automatic host_write(input ami_pkg::addr_t addr, input ami_pkg::word_t data);
    @(posedge clk);
    host_wr    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(posedge clk);
    host_wr     <= 1'b0;
    model[addr] = data;
  endtask

  task automatic read_check(input ami_pkg::addr_t addr);
    int waited;
    @(posedge clk);
    host_rd   <= 1'b1;
    host_addr <= addr;
    exp_rdata <= model[addr];
    @(posedge clk);
    host_rd <= 1'b0;
    waited  = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!host_rd_valid && waited < READ_TIMEOUT);
    if (!host_rd_valid) begin
      abort_run($sformatf("no read data came back for address %0d", addr));
    end
  endtask

  task automatic verify_memory();
    for (int a = 0; a < ami_pkg::MEM_WORDS; a++) begin
      read_check(ami_pkg::addr_t'(a));
    end
  endtask

  task automatic pulse_start(input drive_pkg::run_cfg_t c);
    @(posedge clk);
    run_start <= 1'b1;
    run_cfg   <= c;
    @(posedge clk);
    run_start <= 1'b0;
  endtask

  // Two words take about five cycles with two items open
  task automatic start_run(input drive_pkg::run_cfg_t c);
    min_cycles <= drive_pkg::cycle_t'(c.count) + 32'd3;
    max_cycles <= (c.count == '0) ? 32'd4 : drive_pkg::cycle_t'(c.count) * 32'd4 + 32'd10;
    pulse_start(c);
  endtask

  task automatic wait_run_done();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!run_done && waited < RUN_TIMEOUT);
    if (!run_done) begin
      abort_run("run_done never arrived after run_start");
    end
  endtask

  task automatic model_and_run(input drive_pkg::run_cfg_t c);
    apply_model(c);
    start_run(c);
    wait_run_done();
  endtask

  // ************************************************************
  // Reporting
  // ************************************************************

  task automatic report_test(input string name);
    @(posedge clk);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("Test %0d %-24s passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %-24s failed with %0d errors", tests_run, name,
               error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  task automatic finish_run();
    @(posedge clk);
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (timed_out || tests_failed != 0 || error_count != 0) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  endtask

  task automatic abort_run(input string reason);
    $display("Timeout at %0t: %s", $time, reason);
    timed_out = 1'b1;
    finish_run();
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    drive_pkg::run_cfg_t cfg_a;
    drive_pkg::run_cfg_t cfg_b;
    ami_pkg::addr_t      addr;
    rst             = 1'b1;
    run_start       = 1'b0;
    run_cfg         = '0;
    host_wr         = 1'b0;
    host_rd         = 1'b0;
    host_addr       = '0;
    host_wdata      = '0;
    exp_rdata       = '0;
    min_cycles      = '0;
    max_cycles      = '0;
    rand_state      = 32'd3253;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    timed_out       = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Whole memory gets known contents first
    for (int a = 0; a < ami_pkg::MEM_WORDS; a++) begin
      host_write(ami_pkg::addr_t'(a), random_word());
    end

    for (int i = 0; i < 16; i++) begin
      addr = ami_pkg::addr_t'(rand_below(ami_pkg::MEM_WORDS));
      host_write(addr, random_word());
      read_check(addr);
    end
    report_test("host write and read");

    model_and_run(random_cfg(1, 40, 1'b0));
    verify_memory();
    report_test("single run");

    model_and_run(random_cfg(1, 40, 1'b1));
    verify_memory();
    report_test("in-place run");

    model_and_run(random_cfg(0, 0, 1'b0));
    verify_memory();
    report_test("empty run");

    // Second start lands while the first run is busy
    cfg_a = random_cfg(5, 40, 1'b0);
    cfg_b = random_cfg(5, 40, 1'b0);
    apply_model(cfg_a);
    start_run(cfg_a);
    pulse_start(cfg_b);
    wait_run_done();
    verify_memory();
    report_test("start while busy");

    for (int r = 0; r < 5; r++) begin
      model_and_run(random_cfg(1, 40, rand_below(2) == 1));
    end
    verify_memory();
    report_test("back-to-back runs");

    finish_run();
  end

endmodule

`default_nettype wire

/* flist.f */
source/ami_pkg.sv
source/drive_pkg.sv
source/run_control.sv
source/layer_stream_engine.sv
source/req_fifo.sv
source/mem_responder.sv
source/accel_drive_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_accel_drive.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_accel_drive
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
